/* logic/fetch_settings.svh */
/*
 * widths and constants shared by the fetch front end
 * a memory line must hold exactly two instruction words
 * since fetch picks the half by pc bit 2
 */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// core word and byte address width
`define XLEN 32

// one memory line, two instructions
`define LINE_BITS 64

// first fetch address out of reset
`define RESET_PC {`XLEN{1'b0}}

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* logic/core_types_pkg.sv */
/*
 * core side types of the fetch front end
 * src_vec_t keeps the highest priority source in its top bit
 */
`default_nettype none
`include "fetch_settings.svh"

package core_types_pkg;

    // byte address
    typedef logic [`XLEN-1:0] addr_t;

    typedef logic [31:0] inst_t;

    // one request or grant bit per pc source
    typedef logic [3:0] src_vec_t;

    // bit positions inside src_vec_t
    localparam int unsigned SRC_BRANCH = 3;
    localparam int unsigned SRC_ROB = 2;
    localparam int unsigned SRC_PRED = 1;
    localparam int unsigned SRC_SEQ = 0;

    typedef enum logic {
        FETCH_SELECT,
        FETCH_WAIT
    } fetch_state_t;

endpackage

`default_nettype wire

/* logic/mem_types_pkg.sv */
/*
 * memory side types of the fetch front end
 * a line address drops the byte offset inside one line
 */
`default_nettype none
`include "fetch_settings.svh"

package mem_types_pkg;

    typedef logic [`LINE_BITS-1:0] line_t;

    // byte offset bits inside one line
    localparam int unsigned LINE_OFFSET_BITS = $clog2(`LINE_BITS / 8);

    typedef logic [`XLEN-LINE_OFFSET_BITS-1:0] line_addr_t;

    typedef enum logic [1:0] {
        LINE_IDLE,
        LINE_BUS,
        LINE_REPLY
    } line_state_t;

endpackage

`default_nettype wire

/* logic/pc_source_select.sv */
/*
 * fixed priority pick over the pc source requests
 * the top bit wins, grant is one-hot or all zero
 */
`timescale 1ns/10ps
`default_nettype none

module pc_source_select (
    input  wire core_types_pkg::src_vec_t requests,
    output core_types_pkg::src_vec_t      grant,
    output logic                          none
);

    import core_types_pkg::*;

    logic found;

    // scan down from the highest priority bit
    always_comb begin
        grant = '0;
        found = 1'b0;
        for (int i = $bits(src_vec_t) - 1; i >= 0; i--) begin
            if (requests[i] && !found) begin
                grant[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign none = (requests == '0);

endmodule

`default_nettype wire

/* logic/ifetch_stage.sv */
/*
 * fetch stage, one instruction in flight at a time
 * line_addr holds steady while line_req is high
 * all state and the packet freeze while fetch_enable is low
 */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_settings.svh"

module ifetch_stage (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          fetch_enable,

    // redirect sources
    input  wire core_types_pkg::addr_t   branch_pc,
    input  wire                          branch_req,
    input  wire core_types_pkg::addr_t   rob_pc,
    input  wire                          rob_req,
    input  wire core_types_pkg::addr_t   pred_pc,
    input  wire                          pred_req,

    // line unit
    output logic                         line_req,
    output mem_types_pkg::line_addr_t    line_addr,
    input  wire mem_types_pkg::line_t    line_data,
    input  wire                          line_valid,

    // packet toward decode
    output core_types_pkg::inst_t        fetch_inst,
    output core_types_pkg::addr_t        fetch_pc,
    output core_types_pkg::addr_t        fetch_npc,
    output logic                         fetch_valid
);

    import core_types_pkg::*;
    import mem_types_pkg::*;

    fetch_state_t state;
    addr_t pc;
    addr_t seq_pc;
    addr_t granted_pc;
    src_vec_t requests;
    src_vec_t grant;
    logic no_request;
    inst_t line_half;

    // sequential source always asks
    assign requests[SRC_BRANCH] = branch_req;
    assign requests[SRC_ROB] = rob_req;
    assign requests[SRC_PRED] = pred_req;
    assign requests[SRC_SEQ] = 1'b1;

    pc_source_select u_select (
        .requests (requests),
        .grant    (grant),
        .none     (no_request)
    );

    assign seq_pc = pc + addr_t'(4);

    always_comb begin
        granted_pc = pc;
        if (no_request) begin
            granted_pc = pc;
        end else if (grant[SRC_BRANCH]) begin
            granted_pc = branch_pc;
        end else if (grant[SRC_ROB]) begin
            granted_pc = rob_pc;
        end else if (grant[SRC_PRED]) begin
            granted_pc = pred_pc;
        end else if (grant[SRC_SEQ]) begin
            granted_pc = seq_pc;
        end
    end

    // pc bit 2 picks the word inside the line
    assign line_half = pc[2] ? line_data[`LINE_BITS-1 -: $bits(inst_t)]
                             : line_data[$bits(inst_t)-1:0];

    assign line_req = (state == FETCH_WAIT);
    assign line_addr = pc[`XLEN-1:LINE_OFFSET_BITS];

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= FETCH_WAIT;
            pc <= `RESET_PC;
            fetch_valid <= 1'b0;
            fetch_inst <= `NOP_INST;
            fetch_pc <= `RESET_PC;
            fetch_npc <= `RESET_PC + addr_t'(4);
        end else if (fetch_enable) begin
            case (state)
                FETCH_SELECT: begin
                    pc <= granted_pc;
                    state <= FETCH_WAIT;
                    // packet goes empty until the line comes back
                    fetch_valid <= 1'b0;
                    fetch_inst <= `NOP_INST;
                    fetch_pc <= pc;
                    fetch_npc <= seq_pc;
                end
                FETCH_WAIT: begin
                    if (line_valid) begin
                        state <= FETCH_SELECT;
                        fetch_valid <= 1'b1;
                        fetch_inst <= line_half;
                        fetch_pc <= pc;
                        fetch_npc <= seq_pc;
                    end
                end
                default: begin
                    state <= FETCH_WAIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/iline_wb_unit.sv */
/*
 * one entry line buffer with a wishbone classic read master
 * hits answer one cycle after the request, misses wait for the ack
 * no bus error handling, wb_err and retry are not supported
 */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_settings.svh"

module iline_wb_unit (
    input  wire                            clock,
    input  wire                            reset,

    // fetch side
    input  wire                            line_req,
    input  wire mem_types_pkg::line_addr_t line_addr,
    output mem_types_pkg::line_t           line_data,
    output logic                           line_valid,

    // wishbone classic master, reads only
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic [`XLEN-1:0]               wb_adr,
    input  wire mem_types_pkg::line_t      wb_dat_r,
    input  wire                            wb_ack
);

    import mem_types_pkg::*;

    line_state_t state;
    line_t buf_line;
    line_addr_t buf_addr;
    logic buf_valid;
    logic hit;
    logic miss_start;
    logic fill;

    assign hit = buf_valid && (buf_addr == line_addr);
    assign miss_start = (state == LINE_IDLE) && line_req && !hit;
    assign fill = (state == LINE_BUS) && wb_ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= LINE_IDLE;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                LINE_IDLE: begin
                    if (line_req && hit) begin
                        state <= LINE_REPLY;
                    end else if (miss_start) begin
                        state <= LINE_BUS;
                        // old line is dropped once the tag moves
                        buf_valid <= 1'b0;
                    end
                end
                LINE_BUS: begin
                    if (fill) begin
                        state <= LINE_REPLY;
                        buf_valid <= 1'b1;
                    end
                end
                LINE_REPLY: begin
                    state <= LINE_IDLE;
                end
                default: begin
                    state <= LINE_IDLE;
                end
            endcase
        end
    end

    // tag and data storage
    always_ff @(posedge clock) begin
        if (miss_start) begin
            buf_addr <= line_addr;
        end
        if (fill) begin
            buf_line <= wb_dat_r;
        end
    end

    assign line_valid = (state == LINE_REPLY);
    assign line_data = buf_line;

    // cyc and stb drop on the edge that samples the ack
    assign wb_cyc = (state == LINE_BUS);
    assign wb_stb = (state == LINE_BUS);
    assign wb_adr = {buf_addr, {LINE_OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
/*
 * fetch front end top, fetch stage plus line unit
 * the wishbone port only reads, wb_we is always low
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          fetch_enable,

    input  wire core_types_pkg::addr_t   branch_pc,
    input  wire                          branch_req,
    input  wire core_types_pkg::addr_t   rob_pc,
    input  wire                          rob_req,
    input  wire core_types_pkg::addr_t   pred_pc,
    input  wire                          pred_req,

    output core_types_pkg::inst_t        fetch_inst,
    output core_types_pkg::addr_t        fetch_pc,
    output core_types_pkg::addr_t        fetch_npc,
    output logic                         fetch_valid,

    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output core_types_pkg::addr_t        wb_adr,
    input  wire mem_types_pkg::line_t    wb_dat_r,
    input  wire                          wb_ack
);

    import mem_types_pkg::*;

    logic line_req;
    line_addr_t line_addr;
    line_t line_data;
    logic line_valid;

    assign wb_we = 1'b0;

    ifetch_stage u_fetch (
        .clock        (clock),
        .reset        (reset),
        .fetch_enable (fetch_enable),
        .branch_pc    (branch_pc),
        .branch_req   (branch_req),
        .rob_pc       (rob_pc),
        .rob_req      (rob_req),
        .pred_pc      (pred_pc),
        .pred_req     (pred_req),
        .line_req     (line_req),
        .line_addr    (line_addr),
        .line_data    (line_data),
        .line_valid   (line_valid),
        .fetch_inst   (fetch_inst),
        .fetch_pc     (fetch_pc),
        .fetch_npc    (fetch_npc),
        .fetch_valid  (fetch_valid)
    );

    iline_wb_unit u_line (
        .clock      (clock),
        .reset      (reset),
        .line_req   (line_req),
        .line_addr  (line_addr),
        .line_data  (line_data),
        .line_valid (line_valid),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

endmodule

`default_nettype wire

/* tb/fetch_tb.sv */
/*
 * testbench for fetch_top with a wishbone classic memory model
 * memory word at byte address a reads as a ^ MEM_KEY
 * redirect targets are kept word aligned
 */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_tb;

    import core_types_pkg::*;
    import mem_types_pkg::*;

    localparam logic [31:0] MEM_KEY = 32'h3C5A_9600;
    localparam int PACKET_BUDGET = 260;
    // select, idle, bus with three wait states, reply, plus stalls
    localparam int WORST_CYCLES = 12;
    localparam int WATCHDOG_NS = (16 + PACKET_BUDGET * WORST_CYCLES) * 4 * 100;

    logic clock, reset, fetch_enable;
    addr_t branch_pc, rob_pc, pred_pc;
    logic branch_req, rob_req, pred_req;
    inst_t fetch_inst;
    addr_t fetch_pc, fetch_npc;
    logic fetch_valid;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    addr_t wb_adr;
    line_t wb_dat_r;

    string test_name;
    int errors, test_errors_start, tests_run, tests_failed;
    int packets, bus_cycles, wait_left;
    addr_t exp_pc, last_pc, last_adr;
    logic last_cyc, last_enable, bus_busy;
    logic [$bits(inst_t)+2*`XLEN:0] last_packet;
    logic [31:0] stim_rand, mem_rand;

    fetch_top dut (.*);

    always #50 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic line_t memory_line(input addr_t adr);
        addr_t base;
        base = {adr[`XLEN-1:3], 3'b000};
        return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected, actual);
        errors++;
        $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
    endtask

    task automatic flag_error(input string text);
        errors++;
        $display("ERROR in %s: %s", test_name, text);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_errors_start);
        end
    endtask

    task automatic wait_packets(input int n);
        int target;
        target = packets + n;
        while (packets < target) @(posedge clock);
    endtask

    // requests stay up until the edge that takes the next packet
    task automatic request_redirect(input logic b, r, p, input addr_t bpc, rpc, ppc);
        branch_req <= b;
        rob_req <= r;
        pred_req <= p;
        branch_pc <= bpc;
        rob_pc <= rpc;
        pred_pc <= ppc;
        wait_packets(1);
        branch_req <= 1'b0;
        rob_req <= 1'b0;
        pred_req <= 1'b0;
    endtask

    // memory slave with zero to three wait states per read
    always @(posedge clock) begin
        if (reset) begin
            wb_ack <= 1'b0;
            bus_busy = 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                mem_rand = xorshift32(mem_rand);
                wait_left = mem_rand % 4;
            end
            if (wait_left == 0) begin
                wb_ack <= 1'b1;
                wb_dat_r <= memory_line(wb_adr);
                bus_busy = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // checks run mid cycle on the values the next edge acts on
    always @(negedge clock) begin
        if (reset) begin
            exp_pc = `RESET_PC;
            last_cyc = 1'b0;
            last_enable = 1'b1;
        end else begin
            if (wb_cyc) begin
                if (!last_cyc) bus_cycles++;
                assert (wb_stb == wb_cyc) else report_mismatch("wb_stb", wb_cyc, wb_stb);
                assert (wb_we == 1'b0) else report_mismatch("wb_we", 0, wb_we);
                assert (wb_adr[2:0] == 3'b000) else report_mismatch("wb_adr align", 0, wb_adr);
                if (last_cyc) begin
                    assert (wb_adr == last_adr)
                    else report_mismatch("wb_adr hold", last_adr, wb_adr);
                end
            end
            if (!last_enable) begin
                assert ({fetch_valid, fetch_inst, fetch_pc, fetch_npc} == last_packet)
                else flag_error("fetch outputs changed while fetch_enable was low");
            end
            // packet taken by decode on the next edge
            if (fetch_valid && fetch_enable) begin
                assert (fetch_pc == exp_pc) else report_mismatch("pc", exp_pc, fetch_pc);
                assert (fetch_inst == (exp_pc ^ MEM_KEY))
                else report_mismatch("inst", exp_pc ^ MEM_KEY, fetch_inst);
                assert (fetch_npc == exp_pc + 32'd4)
                else report_mismatch("npc", exp_pc + 32'd4, fetch_npc);
                last_pc = fetch_pc;
                packets++;
                if (branch_req) exp_pc = branch_pc;
                else if (rob_req) exp_pc = rob_pc;
                else if (pred_req) exp_pc = pred_pc;
                else exp_pc = exp_pc + 32'd4;
            end
            last_cyc = wb_cyc;
            last_adr = wb_adr;
            last_enable = fetch_enable;
            last_packet = {fetch_valid, fetch_inst, fetch_pc, fetch_npc};
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, fetch stopped making progress", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int start_count;
        int target;
        clock = 1'b0;
        reset = 1'b1;
        fetch_enable = 1'b1;
        branch_pc = '0;
        rob_pc = '0;
        pred_pc = '0;
        branch_req = 1'b0;
        rob_req = 1'b0;
        pred_req = 1'b0;
        wb_dat_r = '0;
        wb_ack = 1'b0;
        stim_rand = 32'd33;
        mem_rand = 32'd33;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        packets = 0;
        bus_cycles = 0;
        test_name = "reset";
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        begin_test("sequential");
        wait_packets(6);
        end_test();

        begin_test("priority");
        request_redirect(1'b1, 1'b1, 1'b1, 32'h100, 32'h200, 32'h300);
        wait_packets(1);
        assert (last_pc == 32'h100) else report_mismatch("branch first", 32'h100, last_pc);
        request_redirect(1'b0, 1'b1, 1'b1, 32'h140, 32'h240, 32'h340);
        wait_packets(1);
        assert (last_pc == 32'h240) else report_mismatch("rob second", 32'h240, last_pc);
        request_redirect(1'b0, 1'b0, 1'b1, 32'h180, 32'h280, 32'h380);
        wait_packets(1);
        assert (last_pc == 32'h380) else report_mismatch("pred third", 32'h380, last_pc);
        end_test();

        begin_test("line_reuse");
        request_redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h400);
        start_count = bus_cycles;
        wait_packets(2);
        assert (bus_cycles - start_count == 1)
        else report_mismatch("same line", 1, bus_cycles - start_count);
        wait_packets(1);
        assert (bus_cycles - start_count == 2)
        else report_mismatch("new line", 2, bus_cycles - start_count);
        end_test();

        begin_test("bus_protocol");
        start_count = bus_cycles;
        for (int i = 1; i <= 4; i++) begin
            request_redirect(1'b1, 1'b0, 1'b0, 32'h1000 * i, '0, '0);
            wait_packets(1);
        end
        assert (bus_cycles - start_count == 4)
        else report_mismatch("bus cycles", 4, bus_cycles - start_count);
        end_test();

        begin_test("stall");
        // first stall lands in the wait state and drops a line pulse
        wait_packets(1);
        fetch_enable <= 1'b0;
        repeat (8) @(posedge clock);
        for (int i = 0; i < 24; i++) begin
            @(posedge clock);
            fetch_enable <= (i % 4 == 3);
        end
        fetch_enable <= 1'b1;
        wait_packets(3);
        end_test();

        begin_test("random");
        target = packets + 200;
        while (packets < target) begin
            @(posedge clock);
            stim_rand = xorshift32(stim_rand);
            fetch_enable <= (stim_rand[1:0] != 2'b00);
            branch_req <= (stim_rand[4:2] == 3'b000);
            rob_req <= (stim_rand[7:5] == 3'b000);
            pred_req <= (stim_rand[10:8] == 3'b000);
            branch_pc <= addr_t'({stim_rand[19:12], 2'b00});
            rob_pc <= addr_t'({stim_rand[27:20], 2'b00});
            pred_pc <= addr_t'({stim_rand[31:28], stim_rand[11:8], 2'b00});
        end
        fetch_enable <= 1'b1;
        branch_req <= 1'b0;
        rob_req <= 1'b0;
        pred_req <= 1'b0;
        end_test();

        $display("tests %0d, failed %0d, errors %0d, packets %0d, bus cycles %0d",
                 tests_run, tests_failed, errors, packets, bus_cycles);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/core_types_pkg.sv
logic/mem_types_pkg.sv
logic/pc_source_select.sv
logic/ifetch_stage.sv
logic/iline_wb_unit.sv
logic/fetch_top.sv
tb/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_types_pkg.sv
      - logic/mem_types_pkg.sv
      - logic/pc_source_select.sv
      - logic/ifetch_stage.sv
      - logic/iline_wb_unit.sv
      - logic/fetch_top.sv
      - target: test
        files:
          - tb/fetch_tb.sv
